//--- verilog/cobs_pkg.sv
package cobs_pkg;

    // One byte on either stream
    typedef logic [7:0] byte_t;

    // Longest run of non-zero bytes that one code byte can describe
    localparam int max_run = 254;

    // Stored run length, 0 to 254
    typedef logic [7:0] run_len_t;

    // Code byte of a block that was closed by length alone
    localparam byte_t full_code = 8'hff;

    // Code byte of an empty block
    localparam byte_t empty_code = 8'h01;

    // Frame delimiter, the only zero byte on the encoded stream
    localparam byte_t delim_byte = 8'h00;

    // How the gather stage closed a block
    typedef enum logic [1:0] {
        blk_zero,
        blk_full,
        blk_last,
        blk_zero_last
    } block_kind_t;

    // Emitter FSM states
    typedef enum logic [2:0] {
        em_idle,
        em_code,
        em_data,
        em_tail,
        em_delim
    } emit_state_t;

endpackage

//--- verilog/cobs_block_gather.sv
`timescale 1ns/1ps

module cobs_block_gather import cobs_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    input  byte_t       raw_tdata,
    input  logic        raw_tvalid,
    input  logic        raw_tlast,
    output logic        raw_tready,

    output logic        desc_valid,
    input  logic        desc_ready,
    output block_kind_t desc_kind,
    output run_len_t    desc_len,
    output logic        desc_bank,

    input  logic        rd_bank,
    input  run_len_t    rd_addr,
    output byte_t       rd_data,
    input  logic        bank_free
);

    // Two block buffers, one filling while the other drains
    byte_t       mem [0:1][0:max_run-1];

    // Bank being filled, oldest bank waiting for a descriptor handshake,
    // and oldest bank still held by the emitter
    logic        fill_bank;
    logic        out_bank;
    logic        free_bank;
    run_len_t    cnt;

    // A bank is busy from closure until the emitter frees it, and pending
    // from closure until its descriptor is accepted
    logic [1:0]  busy;
    logic [1:0]  pending;

    // Descriptor fields stored per bank
    block_kind_t kind_q [0:1];
    run_len_t    len_q [0:1];

    logic        raw_xfer;
    logic        is_zero;
    logic        close_blk;
    block_kind_t close_kind;
    run_len_t    close_len;

    assign raw_tready = !busy[fill_bank];
    assign raw_xfer   = raw_tvalid && raw_tready;
    assign is_zero    = (raw_tdata == delim_byte);

    // The 254th non-zero byte ends the block even without a zero
    assign close_blk = raw_xfer &&
                       (is_zero || raw_tlast || cnt == run_len_t'(max_run - 1));

    always_comb begin
        if (is_zero) begin
            // The zero itself is implied by the code byte and not stored
            close_kind = raw_tlast ? blk_zero_last : blk_zero;
            close_len  = cnt;
        end else begin
            // Last flag wins over a full run, the code byte is 0xFF either way
            close_kind = raw_tlast ? blk_last : blk_full;
            close_len  = cnt + 8'd1;
        end
    end

    // Descriptors leave in the order their banks were closed
    assign desc_valid = pending[out_bank];
    assign desc_kind  = kind_q[out_bank];
    assign desc_len   = len_q[out_bank];
    assign desc_bank  = out_bank;

    always_ff @(posedge clk) begin
        if (raw_xfer && !is_zero) begin
            mem[fill_bank][cnt] <= raw_tdata;
        end
        rd_data <= mem[rd_bank][rd_addr];
    end

    always_ff @(posedge clk) begin
        if (close_blk) begin
            kind_q[fill_bank] <= close_kind;
            len_q[fill_bank]  <= close_len;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fill_bank <= 1'b0;
            out_bank  <= 1'b0;
            free_bank <= 1'b0;
            cnt       <= '0;
            busy      <= 2'b00;
            pending   <= 2'b00;
        end else begin
            if (raw_xfer) begin
                if (close_blk) begin
                    cnt       <= '0;
                    fill_bank <= !fill_bank;
                end else begin
                    cnt <= cnt + 8'd1;
                end
            end

            if (desc_valid && desc_ready) begin
                pending[out_bank] <= 1'b0;
                out_bank          <= !out_bank;
            end

            // Banks come back in the same order they were handed out
            if (bank_free) begin
                busy[free_bank] <= 1'b0;
                free_bank       <= !free_bank;
            end

            // A bank can only close while it is free, so these never
            // touch the same bit as the clears above
            if (close_blk) begin
                busy[fill_bank]    <= 1'b1;
                pending[fill_bank] <= 1'b1;
            end
        end
    end

endmodule

//--- verilog/cobs_block_emit.sv
`timescale 1ns/1ps

module cobs_block_emit import cobs_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,

    input  logic        desc_valid,
    output logic        desc_ready,
    input  block_kind_t desc_kind,
    input  run_len_t    desc_len,
    input  logic        desc_bank,

    output logic        rd_bank,
    output run_len_t    rd_addr,
    input  byte_t       rd_data,
    output logic        bank_free,

    output byte_t       enc_tdata,
    output logic        enc_tvalid,
    output logic        enc_tlast,
    input  logic        enc_tready
);

    emit_state_t state;
    emit_state_t after_block;

    // Copy of the accepted descriptor
    block_kind_t kind_q;
    run_len_t    len_q;
    logic        bank_q;
    byte_t       code_q;

    // Index of the stored byte that rd_data currently holds
    run_len_t    idx;

    logic        enc_xfer;
    logic        last_data;

    assign desc_ready = (state == em_idle);
    assign enc_tvalid = (state != em_idle);
    assign enc_tlast  = (state == em_delim);
    assign enc_xfer   = enc_tvalid && enc_tready;

    // Only meaningful in em_data, where len_q is at least one
    assign last_data = (idx == len_q - 8'd1);

    // What follows the data bytes depends on how the block was closed
    always_comb begin
        case (kind_q)
            blk_zero_last: after_block = em_tail;
            blk_last:      after_block = em_delim;
            default:       after_block = em_idle;
        endcase
    end

    always_comb begin
        case (state)
            em_code: enc_tdata = code_q;
            em_data: enc_tdata = rd_data;
            em_tail: enc_tdata = empty_code;
            default: enc_tdata = delim_byte;
        endcase
    end

    // While idle the first byte of the offered bank is fetched, so it is
    // already in rd_data when the code byte goes out
    assign rd_bank = (state == em_idle) ? desc_bank : bank_q;

    always_comb begin
        if (state == em_idle) begin
            rd_addr = '0;
        end else if (state == em_data && enc_tready && !last_data) begin
            // Fetch the next byte during the current transfer
            rd_addr = idx + 8'd1;
        end else begin
            // Re-read the same byte so that a stalled output stays put
            rd_addr = idx;
        end
    end

    always_ff @(posedge clk) begin
        if (desc_valid && desc_ready) begin
            kind_q <= desc_kind;
            len_q  <= desc_len;
            bank_q <= desc_bank;
            code_q <= (desc_kind == blk_full) ? full_code : desc_len + 8'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= em_idle;
            idx       <= '0;
            bank_free <= 1'b0;
        end else begin
            bank_free <= 1'b0;
            case (state)
                em_idle: begin
                    if (desc_valid) begin
                        state <= em_code;
                        idx   <= '0;
                    end
                end
                em_code: begin
                    if (enc_xfer) begin
                        if (len_q == '0) begin
                            // Empty block, nothing to read from the bank
                            state     <= after_block;
                            bank_free <= 1'b1;
                        end else begin
                            state <= em_data;
                        end
                    end
                end
                em_data: begin
                    if (enc_xfer) begin
                        if (last_data) begin
                            state     <= after_block;
                            bank_free <= 1'b1;
                        end else begin
                            idx <= idx + 8'd1;
                        end
                    end
                end
                em_tail: begin
                    if (enc_xfer) begin
                        state <= em_delim;
                    end
                end
                em_delim: begin
                    if (enc_xfer) begin
                        state <= em_idle;
                    end
                end
                default: begin
                    state <= em_idle;
                end
            endcase
        end
    end

endmodule

//--- verilog/cobs_encode_wrapper.sv
`timescale 1ns/1ps

module cobs_encode_wrapper import cobs_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,

    input  byte_t raw_tdata,
    input  logic  raw_tvalid,
    input  logic  raw_tlast,
    output logic  raw_tready,

    output byte_t enc_tdata,
    output logic  enc_tvalid,
    output logic  enc_tlast,
    input  logic  enc_tready
);

    // Block descriptor from gather to emit
    logic        desc_valid;
    logic        desc_ready;
    block_kind_t desc_kind;
    run_len_t    desc_len;
    logic        desc_bank;

    // Bank read port and release
    logic        rd_bank;
    run_len_t    rd_addr;
    byte_t       rd_data;
    logic        bank_free;

    cobs_block_gather i_cobs_block_gather (
        .clk        (clk),
        .rst_n      (rst_n),
        .raw_tdata  (raw_tdata),
        .raw_tvalid (raw_tvalid),
        .raw_tlast  (raw_tlast),
        .raw_tready (raw_tready),
        .desc_valid (desc_valid),
        .desc_ready (desc_ready),
        .desc_kind  (desc_kind),
        .desc_len   (desc_len),
        .desc_bank  (desc_bank),
        .rd_bank    (rd_bank),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .bank_free  (bank_free)
    );

    cobs_block_emit i_cobs_block_emit (
        .clk        (clk),
        .rst_n      (rst_n),
        .desc_valid (desc_valid),
        .desc_ready (desc_ready),
        .desc_kind  (desc_kind),
        .desc_len   (desc_len),
        .desc_bank  (desc_bank),
        .rd_bank    (rd_bank),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .bank_free  (bank_free),
        .enc_tdata  (enc_tdata),
        .enc_tvalid (enc_tvalid),
        .enc_tlast  (enc_tlast),
        .enc_tready (enc_tready)
    );

endmodule

//--- sim/cobs_encode_wrapper_asserts.sv
`timescale 1ns/1ps

module cobs_encode_wrapper_asserts import cobs_pkg::*; (
    input logic  clk,
    input logic  rst_n,
    input byte_t enc_tdata,
    input logic  enc_tvalid,
    input logic  enc_tlast,
    input logic  enc_tready
);

    // Number of failed assertions, read by the testbench at the end
    int fail_count = 0;

    // A stalled output byte stays put until the sink takes it
    stall_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        enc_tvalid && !enc_tready |=> enc_tvalid && $stable(enc_tdata) && $stable(enc_tlast)
    ) else begin
        fail_count++;
        $error("encoded byte changed while the sink was stalling");
    end

    // Only the delimiter may be zero
    no_inner_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        enc_tvalid && enc_tready && !enc_tlast |-> enc_tdata != delim_byte
    ) else begin
        fail_count++;
        $error("zero byte transferred inside a frame");
    end

    last_is_delim: assert property (
        @(posedge clk) disable iff (!rst_n)
        enc_tvalid && enc_tready && enc_tlast |-> enc_tdata == delim_byte
    ) else begin
        fail_count++;
        $error("frame ended on a non-zero byte");
    end

endmodule

bind cobs_encode_wrapper cobs_encode_wrapper_asserts i_cobs_encode_wrapper_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .enc_tdata  (enc_tdata),
    .enc_tvalid (enc_tvalid),
    .enc_tlast  (enc_tlast),
    .enc_tready (enc_tready)
);

//--- sim/cobs_encode_wrapper_tb.sv
`timescale 1ns/1ps

module cobs_encode_wrapper_tb import cobs_pkg::*; ();

    logic  clk;
    logic  rst_n;
    byte_t raw_tdata;
    logic  raw_tvalid;
    logic  raw_tlast;
    logic  raw_tready;
    byte_t enc_tdata;
    logic  enc_tvalid;
    logic  enc_tlast;
    logic  enc_tready;

    int    seed;
    int    error_count = 0;
    int    errors_before = 0;
    int    pass_tests = 0;
    int    fail_tests = 0;
    int    cycles = 0;
    int    cycle_limit = 1000;

    // Negedges on which an input byte waited for raw_tready
    int    in_stall_cycles = 0;

    // Stimulus and expected output of the running test
    byte_t in_bytes[$];
    logic  in_last[$];
    byte_t exp_bytes[$];
    int    exp_len[$];
    byte_t frame_buf[$];
    byte_t model_out[$];
    byte_t model_block[$];

    cobs_encode_wrapper i_cobs_encode_wrapper (
        .clk        (clk),
        .rst_n      (rst_n),
        .raw_tdata  (raw_tdata),
        .raw_tvalid (raw_tvalid),
        .raw_tlast  (raw_tlast),
        .raw_tready (raw_tready),
        .enc_tdata  (enc_tdata),
        .enc_tvalid (enc_tvalid),
        .enc_tlast  (enc_tlast),
        .enc_tready (enc_tready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Each queued frame raises the limit by eight cycles per input and output byte
    initial begin
        while (cycles <= cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run stopped after %0d cycles before all tests finished", cycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic compare_byte(input string name, input byte_t expected, input byte_t actual);
        if (actual !== expected) begin
            $display("error %s expected 0x%02h got 0x%02h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic compare_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error %s expected 0x%0h got 0x%0h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic report_fail(input string msg);
        $display("%s", msg);
        error_count++;
    endtask

    // Closes one model block and appends it behind its code byte
    task automatic flush_block(input byte_t code);
        model_out.push_back(code);
        foreach (model_block[i]) begin
            model_out.push_back(model_block[i]);
        end
        model_block.delete();
    endtask

    task automatic encode_model(input byte_t frame[$]);
        model_out.delete();
        model_block.delete();
        foreach (frame[i]) begin
            if (frame[i] == 8'h00) begin
                flush_block(byte_t'(model_block.size() + 1));
            end else begin
                model_block.push_back(frame[i]);
                if (model_block.size() == max_run) begin
                    flush_block(8'hff);
                end
            end
        end
        // A final zero leaves an empty block behind, a final full run leaves nothing
        if (frame[$] == 8'h00 || model_block.size() > 0) begin
            flush_block(byte_t'(model_block.size() + 1));
        end
        model_out.push_back(8'h00);
    endtask

    task automatic queue_frame_expect(input byte_t frame[$], input byte_t expected[$]);
        foreach (frame[i]) begin
            in_bytes.push_back(frame[i]);
            in_last.push_back(i == frame.size() - 1);
        end
        foreach (expected[i]) begin
            exp_bytes.push_back(expected[i]);
        end
        exp_len.push_back(expected.size());
        cycle_limit += 8 * (frame.size() + expected.size());
    endtask

    task automatic queue_frame(input byte_t frame[$]);
        encode_model(frame);
        queue_frame_expect(frame, model_out);
    endtask

    task automatic make_frame(input int len, input int unsigned zero_pct);
        frame_buf.delete();
        for (int i = 0; i < len; i++) begin
            if (rand_below(100) < zero_pct) begin
                frame_buf.push_back(8'h00);
            end else begin
                frame_buf.push_back(byte_t'(rand_below(255) + 1));
            end
        end
    endtask

    task automatic drive_input(input int unsigned gap_pct);
        int i;
        i = 0;
        while (i < in_bytes.size()) begin
            @(negedge clk);
            if (rand_below(100) < gap_pct) begin
                raw_tvalid = 1'b0;
            end else begin
                raw_tvalid = 1'b1;
                raw_tdata  = in_bytes[i];
                raw_tlast  = in_last[i];
                // raw_tready comes from registers only, so it is settled here
                while (!raw_tready) begin
                    in_stall_cycles++;
                    @(negedge clk);
                end
                i++;
            end
        end
        @(negedge clk);
        raw_tvalid = 1'b0;
        raw_tlast  = 1'b0;
    endtask

    task automatic collect_output(input int unsigned stall_pct);
        int frame;
        int cnt;
        int base;
        frame = 0;
        cnt   = 0;
        base  = 0;
        while (frame < exp_len.size()) begin
            @(negedge clk);
            enc_tready = (rand_below(100) >= stall_pct);
            if (enc_tvalid && enc_tready) begin
                if (cnt < exp_len[frame]) begin
                    compare_byte("enc_tdata", exp_bytes[base + cnt], enc_tdata);
                    compare_flag("enc_tlast", cnt == exp_len[frame] - 1, enc_tlast);
                end else if (cnt == exp_len[frame]) begin
                    report_fail($sformatf("frame %0d runs past its %0d expected bytes",
                                          frame, exp_len[frame]));
                end
                cnt++;
                if (enc_tlast) begin
                    if (cnt < exp_len[frame]) begin
                        report_fail($sformatf("frame %0d ended after %0d bytes, %0d expected",
                                              frame, cnt, exp_len[frame]));
                    end
                    base += exp_len[frame];
                    frame++;
                    cnt = 0;
                end
            end
        end
        @(negedge clk);
        enc_tready = 1'b1;
    endtask

    task automatic run_traffic(input int unsigned gap_pct, input int unsigned stall_pct);
        fork
            drive_input(gap_pct);
            collect_output(stall_pct);
        join
    endtask

    task automatic start_test();
        in_bytes.delete();
        in_last.delete();
        exp_bytes.delete();
        exp_len.delete();
        errors_before = error_count;
    endtask

    task automatic finish_test(input string name);
        if (error_count == errors_before) begin
            $display("%s: ok", name);
            pass_tests++;
        end else begin
            $display("%s: failed with %0d errors", name, error_count - errors_before);
            fail_tests++;
        end
    endtask

    task automatic check_reference_frame();
        byte_t frame[$];
        byte_t expected[$];
        start_test();
        // Right after reset the input is open and nothing is offered
        compare_flag("raw_tready", 1'b1, raw_tready);
        compare_flag("enc_tvalid", 1'b0, enc_tvalid);
        frame    = '{8'h69, 8'h70};
        expected = '{8'h03, 8'h69, 8'h70, 8'h00};
        queue_frame_expect(frame, expected);
        run_traffic(0, 0);
        finish_test("reference frame");
    endtask

    task automatic embedded_zero_frames();
        byte_t frame[$];
        byte_t expected[$];
        start_test();
        frame    = '{8'h11, 8'h00, 8'h00, 8'h22};
        expected = '{8'h02, 8'h11, 8'h01, 8'h02, 8'h22, 8'h00};
        queue_frame_expect(frame, expected);
        frame    = '{8'h33, 8'h00};
        expected = '{8'h02, 8'h33, 8'h01, 8'h00};
        queue_frame_expect(frame, expected);
        run_traffic(0, 0);
        finish_test("embedded zeros");
    endtask

    task automatic long_run_frames();
        start_test();
        make_frame(300, 0);
        queue_frame(frame_buf);
        make_frame(254, 0);
        queue_frame(frame_buf);
        run_traffic(0, 0);
        finish_test("long runs");
    endtask

    task automatic random_stall_frames();
        start_test();
        repeat (6) begin
            make_frame(1 + int'(rand_below(400)), 15);
            queue_frame(frame_buf);
        end
        run_traffic(20, 40);
        finish_test("random stalls");
    endtask

    // Output stalls fill both banks so raw_tready drops between bytes
    task automatic back_to_back_frames();
        start_test();
        in_stall_cycles = 0;
        repeat (8) begin
            make_frame(1 + int'(rand_below(300)), 10);
            queue_frame(frame_buf);
        end
        run_traffic(0, 60);
        if (in_stall_cycles == 0) begin
            report_fail("raw_tready never dropped while input bytes were waiting");
        end
        finish_test("back to back frames");
    endtask

    initial begin
        rst_n      = 1'b0;
        raw_tdata  = 8'h00;
        raw_tvalid = 1'b0;
        raw_tlast  = 1'b0;
        enc_tready = 1'b0;
        seed       = 32'hbb20_0b1e;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        check_reference_frame();
        embedded_zero_frames();
        long_run_frames();
        random_stall_frames();
        back_to_back_frames();

        $display("%0d tests passed, %0d tests failed, %0d assertion failures",
                 pass_tests, fail_tests,
                 i_cobs_encode_wrapper.i_cobs_encode_wrapper_asserts.fail_count);
        if (fail_tests == 0 &&
            i_cobs_encode_wrapper.i_cobs_encode_wrapper_asserts.fail_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- src.f
verilog/cobs_pkg.sv
verilog/cobs_block_gather.sv
verilog/cobs_block_emit.sv
verilog/cobs_encode_wrapper.sv
sim/cobs_encode_wrapper_asserts.sv
sim/cobs_encode_wrapper_tb.sv

//--- Makefile
# Verilator build and run of the COBS encoder testbench

VERILATOR ?= verilator
TOP       ?= cobs_encode_wrapper_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Pass message not found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
